// ==== Makefile ====
TOP := csr_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [31:0] xlen_t;     // Data word, address or CSR value
    typedef logic [11:0] csr_idx_t;  // CSR index from the instruction
    typedef logic [3:0]  cause_t;    // MCAUSE exception code field
    typedef logic [2:0]  irq_vec_t;  // One bit per machine interrupt

    // Bit positions inside irq_vec_t
    localparam int IRQ_SW    = 0;
    localparam int IRQ_TIMER = 1;
    localparam int IRQ_EXT   = 2;

    // funct3 encodings of the CSR instructions
    typedef enum logic [2:0] {
        CSR_NONE = 3'b000,
        CSR_RW   = 3'b001,
        CSR_RS   = 3'b010,
        CSR_RC   = 3'b011,
        CSR_RWI  = 3'b101,
        CSR_RSI  = 3'b110,
        CSR_RCI  = 3'b111
    } csr_op_e;

    typedef enum logic [1:0] {
        CLASS_OTHER,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_SYSTEM
    } op_class_e;

    // Machine trap setup and handling registers
    localparam csr_idx_t CSR_MSTATUS  = 12'h300;
    localparam csr_idx_t CSR_MISA     = 12'h301;
    localparam csr_idx_t CSR_MIE      = 12'h304;
    localparam csr_idx_t CSR_MTVEC    = 12'h305;
    localparam csr_idx_t CSR_MSCRATCH = 12'h340;
    localparam csr_idx_t CSR_MEPC     = 12'h341;
    localparam csr_idx_t CSR_MCAUSE   = 12'h342;
    localparam csr_idx_t CSR_MTVAL    = 12'h343;
    localparam csr_idx_t CSR_MIP      = 12'h344;

    // Interrupt codes, MCAUSE bit 31 set
    localparam cause_t CAUSE_SW_IRQ    = 4'd3;
    localparam cause_t CAUSE_TIMER_IRQ = 4'd7;
    localparam cause_t CAUSE_EXT_IRQ   = 4'd11;

    // Exception codes
    localparam cause_t CAUSE_ILLEGAL        = 4'd2;
    localparam cause_t CAUSE_EBREAK         = 4'd3;
    localparam cause_t CAUSE_LOAD_MISALIGN  = 4'd4;
    localparam cause_t CAUSE_STORE_MISALIGN = 4'd6;
    localparam cause_t CAUSE_ECALL          = 4'd11;

    localparam xlen_t MISA_VALUE = 32'h4000_0100;  // MXL 32, base integer ISA

    typedef struct packed {
        op_class_e op_class;    // Instruction class from the decoder
        logic [2:0] funct3;     // CSR operation or load/store size
        csr_idx_t   index;      // CSR index
        xlen_t      imm;        // Zero-extended uimm for the immediate forms
        xlen_t      rs1;
        xlen_t      alu_result; // Load/store address
        xlen_t      pc;
    } csr_cmd_t;

    typedef struct packed {
        logic illegal;
        logic ecall;
        logic ebreak;
        logic mret;
    } exc_flags_t;

    typedef struct packed {
        logic     mstatus_mie;  // Global machine interrupt enable
        irq_vec_t mie;          // Per-source enables
        irq_vec_t mip;          // Sampled pending lines
    } irq_state_t;

    typedef struct packed {
        logic   take;           // Trap taken this cycle
        logic   is_interrupt;
        logic   addr_fault;     // Misaligned load/store, MTVAL gets the address
        cause_t cause;
    } trap_info_t;

endpackage

`default_nettype wire

// ==== design/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile #(
    parameter csr_pkg::xlen_t TRAP_ADDRESS = '0
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire csr_pkg::csr_cmd_t   i_cmd,
    input  wire logic                i_csr_access,
    input  wire logic                i_mret,
    input  wire csr_pkg::trap_info_t i_trap,
    input  wire csr_pkg::irq_vec_t   i_irq_lines,
    output csr_pkg::irq_state_t      o_irq,
    output csr_pkg::xlen_t           o_csr_out,
    output csr_pkg::xlen_t           o_return_address,
    output csr_pkg::xlen_t           o_trap_address,
    output logic                     o_go_to_trap_q,
    output logic                     o_return_from_trap_q
);

    localparam logic [1:0] MSTATUS_MPP = 2'b11;  // Machine mode only

    // Architectural state
    logic              mstatus_mie;
    logic              mstatus_mpie;
    csr_pkg::irq_vec_t mie_en;
    csr_pkg::irq_vec_t mip_q;
    csr_pkg::xlen_t    mtvec;
    csr_pkg::xlen_t    mscratch;
    csr_pkg::xlen_t    mepc;
    logic              mcause_int;
    csr_pkg::cause_t   mcause_code;
    csr_pkg::xlen_t    mtval;

    csr_pkg::xlen_t    rdata;     // Current value at i_cmd.index
    csr_pkg::xlen_t    wdata;     // Value after the read-modify-write
    csr_pkg::xlen_t    operand;   // rs1 or the immediate
    csr_pkg::csr_op_e  op;
    csr_pkg::xlen_t    trap_base;
    csr_pkg::xlen_t    trap_target;

    // Read mux, unknown and machine info indices give zero
    always_comb begin
        rdata = '0;
        case (i_cmd.index)
            csr_pkg::CSR_MSTATUS: begin
                rdata[3]     = mstatus_mie;
                rdata[7]     = mstatus_mpie;
                rdata[12:11] = MSTATUS_MPP;
            end
            csr_pkg::CSR_MISA:     rdata = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MIE: begin
                rdata[3]  = mie_en[csr_pkg::IRQ_SW];     // MSIE
                rdata[7]  = mie_en[csr_pkg::IRQ_TIMER];  // MTIE
                rdata[11] = mie_en[csr_pkg::IRQ_EXT];    // MEIE
            end
            csr_pkg::CSR_MTVEC:    rdata = mtvec;
            csr_pkg::CSR_MSCRATCH: rdata = mscratch;
            csr_pkg::CSR_MEPC:     rdata = mepc;
            csr_pkg::CSR_MCAUSE: begin
                rdata[31]  = mcause_int;
                rdata[3:0] = mcause_code;
            end
            csr_pkg::CSR_MTVAL:    rdata = mtval;
            csr_pkg::CSR_MIP: begin
                rdata[3]  = mip_q[csr_pkg::IRQ_SW];
                rdata[7]  = mip_q[csr_pkg::IRQ_TIMER];
                rdata[11] = mip_q[csr_pkg::IRQ_EXT];
            end
            default:               rdata = '0;
        endcase
    end

    assign op      = csr_pkg::csr_op_e'(i_cmd.funct3);
    assign operand = i_cmd.funct3[2] ? i_cmd.imm : i_cmd.rs1;  // funct3[2] marks immediate forms

    always_comb begin
        case (op)
            csr_pkg::CSR_RW, csr_pkg::CSR_RWI: wdata = operand;
            csr_pkg::CSR_RS, csr_pkg::CSR_RSI: wdata = rdata | operand;
            csr_pkg::CSR_RC, csr_pkg::CSR_RCI: wdata = rdata & ~operand;
            csr_pkg::CSR_NONE:                 wdata = rdata;
            default:                           wdata = rdata;
        endcase
    end

    // Vectored mode adds 4 x cause for interrupts only
    assign trap_base   = {mtvec[31:2], 2'b00};
    assign trap_target = (i_trap.is_interrupt && mtvec[1:0] == 2'b01)
                       ? trap_base + {26'd0, i_trap.cause, 2'b00}
                       : trap_base;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_en       <= '0;
            mip_q        <= '0;
            mtvec        <= TRAP_ADDRESS;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_code  <= '0;
            mtval        <= '0;
        end else begin
            mip_q <= i_irq_lines;  // Pending one edge after the line rises
            if (i_trap.take) begin
                // Trap entry wins over any CSR write or MRET
                mepc         <= i_cmd.pc;
                mcause_int   <= i_trap.is_interrupt;
                mcause_code  <= i_trap.cause;
                mstatus_mpie <= mstatus_mie;  // Stack the enable
                mstatus_mie  <= 1'b0;
                if (i_trap.addr_fault) begin
                    mtval <= i_cmd.alu_result;
                end
            end else begin
                if (i_mret) begin
                    mstatus_mie  <= mstatus_mpie;
                    mstatus_mpie <= 1'b1;
                end
                if (i_csr_access) begin
                    case (i_cmd.index)
                        csr_pkg::CSR_MSTATUS: begin
                            mstatus_mie  <= wdata[3];
                            mstatus_mpie <= wdata[7];
                        end
                        csr_pkg::CSR_MIE: begin
                            mie_en[csr_pkg::IRQ_SW]    <= wdata[3];
                            mie_en[csr_pkg::IRQ_TIMER] <= wdata[7];
                            mie_en[csr_pkg::IRQ_EXT]   <= wdata[11];
                        end
                        csr_pkg::CSR_MTVEC:    mtvec    <= wdata;
                        csr_pkg::CSR_MSCRATCH: mscratch <= wdata;
                        csr_pkg::CSR_MEPC:     mepc     <= {wdata[31:2], 2'b00};
                        csr_pkg::CSR_MCAUSE: begin
                            mcause_int  <= wdata[31];
                            mcause_code <= wdata[3:0];
                        end
                        csr_pkg::CSR_MTVAL:    mtval    <= wdata;
                        default: ;  // MISA, MIP and unknown indices ignore writes
                    endcase
                end
            end
        end
    end

    // Registered outputs, pulses follow the qualified strobes by one edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_csr_out            <= '0;
            o_trap_address       <= '0;
            o_go_to_trap_q       <= 1'b0;
            o_return_from_trap_q <= 1'b0;
        end else begin
            o_go_to_trap_q       <= i_trap.take;
            o_return_from_trap_q <= i_mret;
            if (i_csr_access) begin
                o_csr_out <= rdata;  // Old value goes to rd
            end
            if (i_trap.take) begin
                o_trap_address <= trap_target;
            end
        end
    end

    assign o_return_address = mepc;  // Already holds the pc when the trap pulse is high

    assign o_irq = '{mstatus_mie: mstatus_mie, mie: mie_en, mip: mip_q};

endmodule

`default_nettype wire

// ==== design/csr_trap_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_trap_detect (
    input  wire csr_pkg::csr_cmd_t   i_cmd,
    input  wire csr_pkg::exc_flags_t i_exc,
    input  wire logic                i_stage_en,
    input  wire csr_pkg::irq_state_t i_irq,
    output csr_pkg::trap_info_t      o_trap,
    output logic                     o_csr_access,
    output logic                     o_mret
);

    logic              size_misaligned;
    logic              load_misaligned;
    logic              store_misaligned;
    csr_pkg::irq_vec_t pending;           // Enabled and pending interrupts
    logic              interrupt;
    logic              exception;
    logic              take;

    // funct3[1:0] gives the access size: 01 halfword, 10 word
    always_comb begin
        size_misaligned = 1'b0;
        if (i_cmd.funct3[1:0] == 2'b01) begin
            size_misaligned = i_cmd.alu_result[0];
        end else if (i_cmd.funct3[1:0] == 2'b10) begin
            size_misaligned = |i_cmd.alu_result[1:0];
        end
    end

    assign load_misaligned  = (i_cmd.op_class == csr_pkg::CLASS_LOAD) && size_misaligned;
    assign store_misaligned = (i_cmd.op_class == csr_pkg::CLASS_STORE) && size_misaligned;

    assign pending   = {3{i_irq.mstatus_mie}} & i_irq.mie & i_irq.mip;
    assign interrupt = |pending;
    assign exception = i_exc.illegal || i_exc.ecall || i_exc.ebreak
                     || load_misaligned || store_misaligned;
    assign take      = i_stage_en && (interrupt || exception);

    // Priority chain, interrupts first, external ahead of software and timer
    always_comb begin
        o_trap.take         = take;
        o_trap.is_interrupt = interrupt;
        o_trap.addr_fault   = 1'b0;
        o_trap.cause        = csr_pkg::CAUSE_STORE_MISALIGN;
        if (pending[csr_pkg::IRQ_EXT]) begin
            o_trap.cause = csr_pkg::CAUSE_EXT_IRQ;
        end else if (pending[csr_pkg::IRQ_SW]) begin
            o_trap.cause = csr_pkg::CAUSE_SW_IRQ;
        end else if (pending[csr_pkg::IRQ_TIMER]) begin
            o_trap.cause = csr_pkg::CAUSE_TIMER_IRQ;
        end else if (i_exc.illegal) begin
            o_trap.cause = csr_pkg::CAUSE_ILLEGAL;
        end else if (i_exc.ecall) begin
            o_trap.cause = csr_pkg::CAUSE_ECALL;
        end else if (i_exc.ebreak) begin
            o_trap.cause = csr_pkg::CAUSE_EBREAK;
        end else if (load_misaligned) begin
            o_trap.cause      = csr_pkg::CAUSE_LOAD_MISALIGN;
            o_trap.addr_fault = 1'b1;
        end else begin
            o_trap.addr_fault = store_misaligned;  // Only reached cause left
        end
    end

    // A trap suppresses the access and the return in the same cycle
    assign o_csr_access = (i_cmd.op_class == csr_pkg::CLASS_SYSTEM)
                        && (i_cmd.funct3 != 3'b000) && i_stage_en && !take;
    assign o_mret       = i_exc.mret && i_stage_en && !take;

endmodule

`default_nettype wire

// ==== design/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter csr_pkg::xlen_t TRAP_ADDRESS = '0  // MTVEC reset value
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_stage_en,
    input  wire csr_pkg::csr_cmd_t   i_cmd,
    input  wire csr_pkg::exc_flags_t i_exc,
    input  wire csr_pkg::irq_vec_t   i_irq_lines,
    output csr_pkg::irq_state_t      o_irq,
    output csr_pkg::xlen_t           o_csr_out,
    output csr_pkg::xlen_t           o_return_address,
    output csr_pkg::xlen_t           o_trap_address,
    output logic                     o_go_to_trap_q,
    output logic                     o_return_from_trap_q
);

    csr_pkg::trap_info_t trap;
    logic                csr_access;   // Qualified by stage enable and no trap
    logic                mret;

    // Combinational decode of traps and strobes
    csr_trap_detect csr_trap_detect_i (
        .i_cmd        (i_cmd),
        .i_exc        (i_exc),
        .i_stage_en   (i_stage_en),
        .i_irq        (o_irq),
        .o_trap       (trap),
        .o_csr_access (csr_access),
        .o_mret       (mret)
    );

    csr_regfile #(
        .TRAP_ADDRESS (TRAP_ADDRESS)
    ) csr_regfile_i (
        .i_clk                (i_clk),
        .i_rst_n              (i_rst_n),
        .i_cmd                (i_cmd),
        .i_csr_access         (csr_access),
        .i_mret               (mret),
        .i_trap               (trap),
        .i_irq_lines          (i_irq_lines),
        .o_irq                (o_irq),
        .o_csr_out            (o_csr_out),
        .o_return_address     (o_return_address),
        .o_trap_address       (o_trap_address),
        .o_go_to_trap_q       (o_go_to_trap_q),
        .o_return_from_trap_q (o_return_from_trap_q)
    );

endmodule

`default_nettype wire

// ==== project.f ====
design/csr_pkg.sv
design/csr_trap_detect.sv
design/csr_regfile.sv
design/csr_unit.sv
verification/csr_unit_chk.sv
verification/csr_unit_tb.sv

// ==== verification/csr_unit_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_chk (
    input wire logic              i_clk,
    input wire logic              i_rst_n,
    input wire logic              i_stage_en,
    input wire csr_pkg::csr_cmd_t i_cmd,
    input wire csr_pkg::xlen_t    i_csr_out,
    input wire logic              i_go_to_trap_q,
    input wire logic              i_return_from_trap_q
);

    logic csr_instr;  // Enabled CSR instruction at the unit inputs

    assign csr_instr = i_stage_en && (i_cmd.op_class == csr_pkg::CLASS_SYSTEM)
                     && (i_cmd.funct3 != 3'b000);

    // Trap entry and return never overlap
    a_pulses_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
            !(i_go_to_trap_q && i_return_from_trap_q))
        else $error("Trap and return pulses high in the same cycle");

    // First registered pulses out of reset are low
    a_pulses_low_after_reset: assert property (
        @(posedge i_clk)
            $rose(i_rst_n) |=> (!i_go_to_trap_q && !i_return_from_trap_q))
        else $error("Pulse high in the first cycle after reset");

    // Read value only moves after an enabled CSR instruction
    a_out_holds: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
            !$past(csr_instr) |-> $stable(i_csr_out))
        else $error("o_csr_out changed without a CSR access");

endmodule

`default_nettype wire

// ==== verification/csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

    localparam int             CLK_PERIOD = 40;
    localparam int             RST_CYCLES = 5;
    localparam int             SEED       = 84402;
    localparam csr_pkg::xlen_t TRAP_ADDR  = 32'h100;

    localparam logic [3:0] M_OUT   = 4'b0001;  // Check o_csr_out
    localparam logic [3:0] M_TADDR = 4'b0010;  // Check o_trap_address
    localparam logic [3:0] M_RADDR = 4'b0100;  // Check o_return_address
    localparam logic [3:0] M_IRQ   = 4'b1000;  // Check o_irq

    localparam csr_pkg::exc_flags_t EXC_NONE      = '0;
    localparam csr_pkg::exc_flags_t EXC_ILL_ECALL =
        '{illegal: 1'b1, ecall: 1'b1, ebreak: 1'b0, mret: 1'b0};
    localparam csr_pkg::exc_flags_t EXC_MRET      =
        '{illegal: 1'b0, ecall: 1'b0, ebreak: 1'b0, mret: 1'b1};
    localparam csr_pkg::irq_vec_t   IRQ_NONE  = 3'b000;
    localparam csr_pkg::irq_vec_t   IRQ_TIMER = 3'b010;
    localparam csr_pkg::irq_vec_t   IRQ_EXT   = 3'b100;

    typedef struct packed {
        csr_pkg::csr_cmd_t   cmd;
        csr_pkg::exc_flags_t exc;
        csr_pkg::irq_vec_t   irq;
        logic                en;
        logic [3:0]          mask;
        csr_pkg::xlen_t      exp_out;
        logic                exp_trap;
        logic                exp_ret;
        csr_pkg::xlen_t      exp_taddr;
        csr_pkg::xlen_t      exp_raddr;
        csr_pkg::irq_state_t exp_irq;
    } row_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                stage_en;
    csr_pkg::csr_cmd_t   cmd;
    csr_pkg::exc_flags_t exc;
    csr_pkg::irq_vec_t   irq_lines;
    csr_pkg::irq_state_t irq_state;
    csr_pkg::xlen_t      csr_out;
    csr_pkg::xlen_t      ret_addr;
    csr_pkg::xlen_t      trap_addr;
    logic                go_to_trap;
    logic                ret_from_trap;

    row_t rows[$];
    int   n_rows = 0;  // Set once the table is built

    csr_unit #(
        .TRAP_ADDRESS (TRAP_ADDR)
    ) csr_unit_i (
        .i_clk                (clk),
        .i_rst_n              (rst_n),
        .i_stage_en           (stage_en),
        .i_cmd                (cmd),
        .i_exc                (exc),
        .i_irq_lines          (irq_lines),
        .o_irq                (irq_state),
        .o_csr_out            (csr_out),
        .o_return_address     (ret_addr),
        .o_trap_address       (trap_addr),
        .o_go_to_trap_q       (go_to_trap),
        .o_return_from_trap_q (ret_from_trap)
    );

    bind csr_unit csr_unit_chk csr_unit_chk_i (
        .i_clk                (i_clk),
        .i_rst_n              (i_rst_n),
        .i_stage_en           (i_stage_en),
        .i_cmd                (i_cmd),
        .i_csr_out            (o_csr_out),
        .i_go_to_trap_q       (o_go_to_trap_q),
        .i_return_from_trap_q (o_return_from_trap_q)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic csr_pkg::csr_cmd_t sys_cmd(input csr_pkg::csr_op_e op,
                                                  input csr_pkg::csr_idx_t idx,
                                                  input csr_pkg::xlen_t val);
        csr_pkg::csr_cmd_t c;
        c          = '0;
        c.op_class = csr_pkg::CLASS_SYSTEM;
        c.funct3   = op;
        c.index    = idx;
        if (op[2]) begin
            c.imm = val;  // Immediate forms
        end else begin
            c.rs1 = val;
        end
        return c;
    endfunction

    function automatic csr_pkg::csr_cmd_t mem_cmd(input csr_pkg::op_class_e cls,
                                                  input logic [2:0] f3,
                                                  input csr_pkg::xlen_t addr,
                                                  input csr_pkg::xlen_t pc);
        csr_pkg::csr_cmd_t c;
        c            = '0;
        c.op_class   = cls;
        c.funct3     = f3;
        c.alu_result = addr;
        c.pc         = pc;
        return c;
    endfunction

    task automatic add_row(input csr_pkg::csr_cmd_t c, input csr_pkg::exc_flags_t e,
                           input csr_pkg::irq_vec_t irq, input logic en,
                           input logic [3:0] mask, input csr_pkg::xlen_t out,
                           input logic trap, input logic ret,
                           input csr_pkg::xlen_t taddr, input csr_pkg::xlen_t raddr);
        rows.push_back('{cmd: c, exc: e, irq: irq, en: en, mask: mask, exp_out: out,
                         exp_trap: trap, exp_ret: ret, exp_taddr: taddr, exp_raddr: raddr,
                         exp_irq: '0});
    endtask

    // Adds an o_irq check to the row just added
    task automatic expect_irq(input csr_pkg::irq_state_t state);
        row_t r;
        r         = rows.pop_back();
        r.exp_irq = state;
        r.mask    = r.mask | M_IRQ;
        rows.push_back(r);
    endtask

    // Set with zero is a plain read
    task automatic read_row(input csr_pkg::csr_idx_t idx, input csr_pkg::xlen_t exp);
        add_row(sys_cmd(csr_pkg::CSR_RS, idx, '0), EXC_NONE, IRQ_NONE, 1'b1, M_OUT, exp,
                1'b0, 1'b0, '0, '0);
    endtask

    task automatic csr_row(input csr_pkg::csr_op_e op, input csr_pkg::csr_idx_t idx,
                           input csr_pkg::xlen_t val, input csr_pkg::xlen_t old);
        add_row(sys_cmd(op, idx, val), EXC_NONE, IRQ_NONE, 1'b1, M_OUT, old,
                1'b0, 1'b0, '0, '0);
    endtask

    task automatic idle_row(input csr_pkg::irq_vec_t irq, input csr_pkg::xlen_t pc);
        add_row(mem_cmd(csr_pkg::CLASS_OTHER, 3'b000, '0, pc), EXC_NONE, irq, 1'b1, '0, '0,
                1'b0, 1'b0, '0, '0);
    endtask

    task automatic build_table();
        csr_pkg::xlen_t    val_a;
        csr_pkg::xlen_t    val_b;
        csr_pkg::xlen_t    val_c;
        csr_pkg::xlen_t    scratch;  // Expected MSCRATCH
        csr_pkg::xlen_t    last_out;
        csr_pkg::csr_cmd_t trap_cmd;
        val_a   = $urandom();
        val_b   = $urandom();
        val_c   = $urandom();
        scratch = '0;
        read_row(csr_pkg::CSR_MTVEC, 32'h100);
        read_row(csr_pkg::CSR_MSTATUS, 32'h1800);    // MPP = 11
        read_row(csr_pkg::CSR_MISA, 32'h4000_0100);
        read_row(12'h7C0, 32'h0);                     // Unknown index
        csr_row(csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, val_a, scratch);
        scratch = val_a;
        csr_row(csr_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, val_b, scratch);
        scratch = scratch | val_b;
        csr_row(csr_pkg::CSR_RC, csr_pkg::CSR_MSCRATCH, val_c, scratch);
        scratch = scratch & ~val_c;
        csr_row(csr_pkg::CSR_RWI, csr_pkg::CSR_MSCRATCH, 32'h15, scratch);
        scratch = 32'h15;
        csr_row(csr_pkg::CSR_RSI, csr_pkg::CSR_MSCRATCH, 32'h0A, scratch);
        scratch = scratch | 32'h0A;
        csr_row(csr_pkg::CSR_RCI, csr_pkg::CSR_MSCRATCH, 32'h03, scratch);
        last_out = scratch;
        scratch  = scratch & ~32'h03;
        // Stage disabled, no write, no trap, read value holds
        add_row(sys_cmd(csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 32'hDEAD_BEEF), EXC_NONE,
                IRQ_NONE, 1'b0, M_OUT, last_out, 1'b0, 1'b0, '0, '0);
        add_row(mem_cmd(csr_pkg::CLASS_OTHER, 3'b000, '0, 32'h2030), EXC_ILL_ECALL,
                IRQ_NONE, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
        read_row(csr_pkg::CSR_MSCRATCH, scratch);
        // Misaligned word load
        add_row(mem_cmd(csr_pkg::CLASS_LOAD, 3'b010, 32'h1006, 32'h2000), EXC_NONE,
                IRQ_NONE, 1'b1, M_TADDR | M_RADDR, '0, 1'b1, 1'b0, 32'h100, 32'h2000);
        read_row(csr_pkg::CSR_MCAUSE, 32'h4);
        read_row(csr_pkg::CSR_MTVAL, 32'h1006);
        add_row(mem_cmd(csr_pkg::CLASS_OTHER, 3'b000, '0, 32'h2010), EXC_ILL_ECALL,
                IRQ_NONE, 1'b1, M_TADDR | M_RADDR, '0, 1'b1, 1'b0, 32'h100, 32'h2010);
        read_row(csr_pkg::CSR_MCAUSE, 32'h2);        // Illegal wins over ecall
        add_row(mem_cmd(csr_pkg::CLASS_STORE, 3'b001, 32'h1002, 32'h2020), EXC_NONE,
                IRQ_NONE, 1'b1, M_RADDR, '0, 1'b0, 1'b0, '0, 32'h2010);
        read_row(csr_pkg::CSR_MTVAL, 32'h1006);
        // External interrupt, MEIE then MSTATUS.MIE
        csr_row(csr_pkg::CSR_RW, csr_pkg::CSR_MIE, 32'h800, 32'h0);
        csr_row(csr_pkg::CSR_RSI, csr_pkg::CSR_MSTATUS, 32'h8, 32'h1800);
        expect_irq({1'b1, IRQ_EXT, IRQ_NONE});        // MIE, enables, pending
        idle_row(IRQ_EXT, 32'h3000);                  // Line not yet sampled
        expect_irq({1'b1, IRQ_EXT, IRQ_EXT});
        add_row(mem_cmd(csr_pkg::CLASS_OTHER, 3'b000, '0, 32'h3004), EXC_NONE, IRQ_EXT,
                1'b1, M_TADDR | M_RADDR, '0, 1'b1, 1'b0, 32'h100, 32'h3004);
        expect_irq({1'b0, IRQ_EXT, IRQ_EXT});         // Trap entry clears MIE
        read_row(csr_pkg::CSR_MCAUSE, 32'h8000_000B);
        read_row(csr_pkg::CSR_MSTATUS, 32'h1880);
        add_row(mem_cmd(csr_pkg::CLASS_OTHER, 3'b000, '0, 32'h3008), EXC_MRET, IRQ_NONE,
                1'b1, M_RADDR, '0, 1'b0, 1'b1, '0, 32'h3004);
        read_row(csr_pkg::CSR_MSTATUS, 32'h1888);
        // Vectored mode, base 0x200
        csr_row(csr_pkg::CSR_RW, csr_pkg::CSR_MTVEC, 32'h201, 32'h100);
        idle_row(IRQ_EXT, 32'h4000);
        trap_cmd    = sys_cmd(csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 32'h0BAD);
        trap_cmd.pc = 32'h4004;
        add_row(trap_cmd, EXC_NONE, IRQ_EXT, 1'b1, M_TADDR | M_RADDR, '0, 1'b1, 1'b0,
                32'h22C, 32'h4004);
        read_row(csr_pkg::CSR_MSCRATCH, scratch);     // Write lost to the trap
        add_row(mem_cmd(csr_pkg::CLASS_OTHER, 3'b000, '0, 32'h4008), EXC_MRET, IRQ_NONE,
                1'b1, M_RADDR, '0, 1'b0, 1'b1, '0, 32'h4004);
        // Timer line with MTIE clear
        idle_row(IRQ_TIMER, 32'h5000);
        idle_row(IRQ_TIMER, 32'h5004);
        expect_irq({1'b1, IRQ_EXT, IRQ_TIMER});       // Pending but not enabled
        add_row(sys_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MIP, '0), EXC_NONE, IRQ_TIMER, 1'b1,
                M_OUT, 32'h80, 1'b0, 1'b0, '0, '0);
        idle_row(IRQ_NONE, 32'h5008);
    endtask

    task automatic check_word(input string name, input csr_pkg::xlen_t got,
                              input csr_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED time=%0t %s got=%b expected=%b", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Pulse mismatch on %s", name);
        end
    endtask

    task automatic check_irq(input string name, input csr_pkg::irq_state_t got,
                             input csr_pkg::irq_state_t exp);
        if (got !== exp) begin
            $display("FAILED time=%0t %s got=%b expected=%b", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Interrupt state mismatch on %s", name);
        end
    endtask

    task automatic apply_row(input row_t r);
        stage_en  = r.en;
        cmd       = r.cmd;
        exc       = r.exc;
        irq_lines = r.irq;
    endtask

    task automatic check_row(input row_t r, input int idx);
        check_bit($sformatf("row %0d o_go_to_trap_q", idx), go_to_trap, r.exp_trap);
        check_bit($sformatf("row %0d o_return_from_trap_q", idx), ret_from_trap, r.exp_ret);
        if (r.mask[0]) begin
            check_word($sformatf("row %0d o_csr_out", idx), csr_out, r.exp_out);
        end
        if (r.mask[1]) begin
            check_word($sformatf("row %0d o_trap_address", idx), trap_addr, r.exp_taddr);
        end
        if (r.mask[2]) begin
            check_word($sformatf("row %0d o_return_address", idx), ret_addr, r.exp_raddr);
        end
        if (r.mask[3]) begin
            check_irq($sformatf("row %0d o_irq", idx), irq_state, r.exp_irq);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        stage_en  = 1'b0;
        cmd       = '0;
        exc       = '0;
        irq_lines = '0;
        void'($urandom(SEED));
        build_table();
        n_rows = rows.size();
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);  // 2 ns after the edge
            @(posedge clk);
            #1;
            check_row(rows[i], i);
            #1;
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // Rows plus reset plus margin
    initial begin
        wait (n_rows > 0);
        #((n_rows + RST_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the stimulus table did not finish in the expected time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
